// ==== logic/alu_pkg.sv ====
package alu_pkg;

    localparam int WORD_W     = 32;
    localparam int RES_W      = 64;
    localparam int DIV_CYCLES = 32;
    localparam int DIV_CNT_W  = $clog2(DIV_CYCLES);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [RES_W-1:0]  res_t;

    // Opcode values follow the existing CPU encoding.
    typedef enum logic [4:0] {
        OP_ADD  = 5'd1,
        OP_SUB  = 5'd2,
        OP_MUL  = 5'd3,
        OP_DIV  = 5'd4,
        OP_SHR  = 5'd5,
        OP_SHL  = 5'd6,
        OP_SHRA = 5'd7,
        OP_ROR  = 5'd8,
        OP_ROL  = 5'd9,
        OP_AND  = 5'd10,
        OP_OR   = 5'd11,
        OP_NEG  = 5'd12,
        OP_XOR  = 5'd13,
        OP_NOR  = 5'd14,
        OP_NOT  = 5'd15
    } alu_op_t;

    typedef struct packed {
        alu_op_t op;
        word_t   a;
        word_t   b;
    } alu_req_t;

    // Shift class covers opcodes 5 to 9.
    function automatic logic op_is_shift(alu_op_t op);
        return op inside {OP_SHR, OP_SHL, OP_SHRA, OP_ROR, OP_ROL};
    endfunction

    function automatic logic op_is_div(alu_op_t op);
        return op == OP_DIV;
    endfunction

endpackage

// ==== logic/alu_arith_logic.sv ====
`timescale 1ns/1ps

module alu_arith_logic
    import alu_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output res_t    result
);

    logic [WORD_W:0] sum;
    logic [WORD_W:0] diff;
    res_t            prod;
    word_t           and_ab;
    word_t           or_ab;
    word_t           xor_ab;
    word_t           nor_ab;
    word_t           not_b;
    word_t           neg_b;

    // Carry out lands in bit 32.
    assign sum = {1'b0, a} + {1'b0, b};

    // A plus inverted B plus one, so bit 32 is the no-borrow bit.
    assign diff = {1'b0, a} + {1'b0, ~b} + {{WORD_W{1'b0}}, 1'b1};

    assign prod = res_t'(a) * res_t'(b);

    assign and_ab = a & b;
    assign or_ab  = a | b;
    assign xor_ab = a ^ b;
    assign nor_ab = ~(a | b);
    assign not_b  = ~b;
    assign neg_b  = not_b + word_t'(1);

    always_comb begin
        case (op)
            OP_ADD: begin
                result = res_t'(sum);
            end
            OP_SUB: begin
                result = res_t'(diff);
            end
            OP_MUL: begin
                result = prod;
            end
            OP_AND: begin
                result = res_t'(and_ab);
            end
            OP_OR: begin
                result = res_t'(or_ab);
            end
            OP_XOR: begin
                result = res_t'(xor_ab);
            end
            OP_NOR: begin
                result = res_t'(nor_ab);
            end
            OP_NOT: begin
                result = res_t'(not_b);
            end
            OP_NEG: begin
                result = res_t'(neg_b);
            end
            // Shifts, divide and unknown codes belong elsewhere.
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== logic/alu_shifter.sv ====
`timescale 1ns/1ps

module alu_shifter
    import alu_pkg::*;
(
    input  alu_op_t    op,
    input  word_t      a,
    input  logic [4:0] amount,
    output res_t       result
);

    logic [2*WORD_W-1:0] dbl;
    logic [2*WORD_W-1:0] ror_full;
    logic [2*WORD_W-1:0] rol_full;
    word_t               shr_v;
    word_t               shl_v;
    word_t               shra_v;
    word_t               sel;

    assign shr_v  = a >> amount;
    assign shl_v  = a << amount;
    assign shra_v = $signed(a) >>> amount;

    // Rotates shift a doubled copy of A and keep one half.
    assign dbl      = {a, a};
    assign ror_full = dbl >> amount;
    assign rol_full = dbl << amount;

    always_comb begin
        case (op)
            OP_SHR: begin
                sel = shr_v;
            end
            OP_SHL: begin
                sel = shl_v;
            end
            OP_SHRA: begin
                sel = shra_v;
            end
            OP_ROR: begin
                sel = ror_full[WORD_W-1:0];
            end
            OP_ROL: begin
                sel = rol_full[2*WORD_W-1:WORD_W];
            end
            default: begin
                sel = '0;
            end
        endcase
    end

    assign result = op_is_shift(op) ? res_t'(sel) : '0;

endmodule

// ==== logic/alu_divider.sv ====
`timescale 1ns/1ps

module alu_divider
    import alu_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  start,
    input  word_t dividend,
    input  word_t divisor,
    output word_t quotient,
    output word_t remainder,
    output logic  busy,
    output logic  done
);

    word_t                rem_q;
    word_t                quo_q;
    word_t                dvsr_q;
    logic [DIV_CNT_W-1:0] cnt;
    logic [WORD_W:0]      shifted;
    logic [WORD_W:0]      trial;
    logic                 iterate;
    logic                 last;

    // Bring the next dividend bit into the partial remainder and try a subtract.
    assign shifted = {rem_q, quo_q[WORD_W-1]};
    assign trial   = shifted - {1'b0, dvsr_q};

    assign iterate = busy & ~done;
    assign last    = cnt == DIV_CNT_W'(DIV_CYCLES - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (iterate) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    done <= 1'b1;
                end
            end else if (done) begin
                // Busy stays up through the done cycle.
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            rem_q  <= '0;
            quo_q  <= dividend;
            dvsr_q <= divisor;
        end else if (iterate) begin
            // Restore when the trial subtract went negative.
            if (trial[WORD_W]) begin
                rem_q <= shifted[WORD_W-1:0];
                quo_q <= {quo_q[WORD_W-2:0], 1'b0};
            end else begin
                rem_q <= trial[WORD_W-1:0];
                quo_q <= {quo_q[WORD_W-2:0], 1'b1};
            end
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;

    a_done_single: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |=> !done
    );

    a_done_after_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |-> $past(busy)
    );

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     start,
    input  alu_req_t req,
    output res_t     c,
    output logic     done,
    output logic     busy
);

    logic  accept;
    logic  div_start;
    logic  comb_accept;
    logic  div_done;
    res_t  al_res;
    res_t  sh_res;
    res_t  comb_res;
    word_t quotient;
    word_t remainder;

    // Requests are only taken while no divide is running.
    assign accept      = start & ~busy;
    assign div_start   = accept & op_is_div(req.op);
    assign comb_accept = accept & ~op_is_div(req.op);

    alu_arith_logic u_arith_logic (
        .op     (req.op),
        .a      (req.a),
        .b      (req.b),
        .result (al_res)
    );

    alu_shifter u_shifter (
        .op     (req.op),
        .a      (req.a),
        .amount (req.b[4:0]),
        .result (sh_res)
    );

    alu_divider u_divider (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (div_start),
        .dividend  (req.a),
        .divisor   (req.b),
        .quotient  (quotient),
        .remainder (remainder),
        .busy      (busy),
        .done      (div_done)
    );

    // Units zero their output for foreign opcodes, so an OR merges them.
    assign comb_res = al_res | sh_res;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            c    <= '0;
            done <= 1'b0;
        end else begin
            done <= comb_accept | div_done;
            if (comb_accept) begin
                c <= comb_res;
            end else if (div_done) begin
                c <= {remainder, quotient};
            end
        end
    end

    a_single_cycle: assert property (
        @(posedge clk) disable iff (!arst_n)
        comb_accept |=> done
    );

    // Busy may only rise after a divide was accepted.
    a_busy_from_div: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(busy) |-> $past(div_start)
    );

endmodule

// ==== tb/alu_tb.sv ====
`timescale 1ns/1ps

module alu_tb
    import alu_pkg::*;
();

    localparam int N_RAND = 8;
    localparam int N_REQ  = 18 + 6 * N_RAND + 6 * (3 + N_RAND) + 2 * N_RAND + 8;

    typedef struct packed {
        res_t        exp;
        int unsigned issue;
        int unsigned lat;
    } pending_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        start;
    alu_req_t    req;
    res_t        c;
    logic        done;
    logic        busy;

    int unsigned cycle   = 0;
    int unsigned issued  = 0;
    int unsigned checked = 0;
    int          seed    = 32'h4162_51cd;
    pending_t    pending[$];
    string       names[$];

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    alu alu_i (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .req    (req),
        .c      (c),
        .done   (done),
        .busy   (busy)
    );

    // Expected result straight from the opcode table and result encoding.
    function automatic res_t alu_ref(logic [4:0] code, word_t a, word_t b);
        word_t r;
        r = a;
        case (code)
            5'd1: return res_t'(a) + res_t'(b);
            5'd2: return {31'd0, a >= b, a - b};
            5'd3: return res_t'(a) * res_t'(b);
            5'd4: begin
                if (b == 32'd0) begin
                    return {a, 32'hffff_ffff};
                end
                return {a % b, a / b};
            end
            5'd5: return {32'd0, a >> b[4:0]};
            5'd6: return {32'd0, a << b[4:0]};
            5'd7: begin
                for (int i = 0; i < int'(b[4:0]); i++) begin
                    r = {r[31], r[31:1]};
                end
                return {32'd0, r};
            end
            5'd8: begin
                for (int i = 0; i < int'(b[4:0]); i++) begin
                    r = {r[0], r[31:1]};
                end
                return {32'd0, r};
            end
            5'd9: begin
                for (int i = 0; i < int'(b[4:0]); i++) begin
                    r = {r[30:0], r[31]};
                end
                return {32'd0, r};
            end
            5'd10: return {32'd0, a & b};
            5'd11: return {32'd0, a | b};
            5'd12: return {32'd0, 32'd0 - b};
            5'd13: return {32'd0, a ^ b};
            5'd14: return {32'd0, ~(a | b)};
            5'd15: return {32'd0, ~b};
            default: return '0;
        endcase
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic send_req(input string name, input logic [4:0] code,
                            input word_t a, input word_t b);
        pending_t e;
        @(negedge clk);
        req.op  = alu_op_t'(code);
        req.a   = a;
        req.b   = b;
        start   = 1'b1;
        e.exp   = alu_ref(code, a, b);
        e.issue = cycle;
        // A divide is taken at the next edge and done follows DIV_CYCLES+1 edges later.
        e.lat   = (code == 5'd4) ? DIV_CYCLES + 2 : 1;
        pending.push_back(e);
        names.push_back(name);
        issued++;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_result();
        wait (checked == issued);
    endtask

    task automatic run_req(input string name, input logic [4:0] code,
                           input word_t a, input word_t b);
        send_req(name, code, a, b);
        wait_result();
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they change.
    always @(negedge clk) begin : compare
        pending_t e;
        string    name;
        if (arst_n === 1'b1 && done === 1'b1) begin
            assert (pending.size() > 0)
                else stop_on_error("done pulsed with no request pending");
            e    = pending.pop_front();
            name = names.pop_front();
            assert (c === e.exp)
                else stop_on_error($sformatf("error %s: expected %h actual %h",
                                             name, e.exp, c));
            assert (cycle - e.issue == e.lat)
                else stop_on_error($sformatf("error %s latency: expected %0d actual %0d",
                                             name, e.lat, cycle - e.issue));
            assert (busy === 1'b0)
                else stop_on_error("busy was still high when done pulsed");
            checked++;
        end else if (pending.size() > 0 && pending[0].lat > 1 && cycle > pending[0].issue) begin
            assert (busy === 1'b1)
                else stop_on_error("busy dropped while a divide was running");
        end
    end

    initial begin : watchdog
        repeat (N_REQ * 40 + 200) @(posedge clk);
        stop_on_error("timeout, done never came for a pending request");
    end

    initial begin : stimulus
        word_t      edges[3];
        logic [4:0] bit_ops[6];
        logic [4:0] shift_ops[5];
        logic [4:0] amounts[3];
        word_t      a;
        word_t      b;
        edges     = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
        bit_ops   = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_NOT, OP_NEG};
        shift_ops = '{OP_SHR, OP_SHL, OP_SHRA, OP_ROR, OP_ROL};
        amounts   = '{5'd0, 5'd1, 5'd31};
        start     = 1'b0;
        req       = '0;
        arst_n    = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        foreach (edges[i]) begin
            foreach (edges[j]) begin
                run_req("add", OP_ADD, edges[i], edges[j]);
                run_req("sub", OP_SUB, edges[i], edges[j]);
            end
        end

        foreach (bit_ops[k]) begin
            for (int n = 0; n < N_RAND; n++) begin
                a = $random(seed);
                b = $random(seed);
                run_req("bitwise", bit_ops[k], a, b);
            end
        end

        foreach (shift_ops[k]) begin
            foreach (amounts[m]) begin
                a = $random(seed);
                run_req("shift", shift_ops[k], a, word_t'(amounts[m]));
            end
            for (int n = 0; n < N_RAND; n++) begin
                a = $random(seed);
                b = $random(seed);
                run_req("shift", shift_ops[k], a, b);
            end
        end

        // Negative A for the sign fill of shra.
        foreach (amounts[m]) begin
            a = $random(seed) | 32'h8000_0000;
            run_req("shra_neg", OP_SHRA, a, word_t'(amounts[m]));
        end
        for (int n = 0; n < N_RAND; n++) begin
            a = $random(seed) | 32'h8000_0000;
            b = $random(seed);
            run_req("shra_neg", OP_SHRA, a, b);
        end

        run_req("mul", OP_MUL, 32'hffff_ffff, 32'hffff_ffff);
        a = $random(seed);
        run_req("mul", OP_MUL, 32'hffff_ffff, a);
        for (int n = 0; n < N_RAND; n++) begin
            a = $random(seed);
            b = $random(seed);
            run_req("mul", OP_MUL, a, b);
        end

        // Smaller divisors further on give larger quotients.
        for (int n = 0; n < N_RAND; n++) begin
            a = $random(seed);
            b = word_t'($random(seed)) >> (4 * n);
            run_req("div", OP_DIV, a, b);
        end
        a = $random(seed);
        run_req("div_zero", OP_DIV, a, 32'd0);
        run_req("div_zero", OP_DIV, 32'hffff_ffff, 32'd0);

        // A start in the middle of a divide must be dropped.
        a = $random(seed);
        b = $random(seed) & 32'h0000_ffff;
        send_req("div_busy", OP_DIV, a, b);
        repeat (10) @(negedge clk);
        req.op = OP_ADD;
        start  = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_result();
        repeat (5) @(negedge clk);

        run_req("illegal", 5'd0, 32'h1234_5678, 32'h9abc_def0);
        run_req("illegal", 5'd16, 32'hffff_ffff, 32'hffff_ffff);
        run_req("illegal", 5'd31, 32'h8000_0000, 32'h0000_0001);

        repeat (5) @(negedge clk);
        if (checked == issued && busy === 1'b0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_on_error("requests left open or busy still high at the end");
        end
    end

endmodule

// ==== vlog.f ====
logic/alu_pkg.sv
logic/alu_arith_logic.sv
logic/alu_shifter.sv
logic/alu_divider.sv
logic/alu.sv
tb/alu_tb.sv

// ==== Makefile ====
TOP := alu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
